//--- Bender.yml
package:
  name: bypass_controller

sources:
  - src/BypassPkg.sv
  - src/DstTagPipe.sv
  - src/BypassSelector.sv
  - src/BypassController.sv
  - target: test
    files:
      - test/BypassController_asserts.sv
      - test/BypassControllerTb.sv

//--- files.f
src/BypassPkg.sv
src/DstTagPipe.sv
src/BypassSelector.sv
src/BypassController.sv
test/BypassController_asserts.sv
test/BypassControllerTb.sv

//--- src/BypassController.sv
/* Bypass controller for the register-read stage
   Tracks int and load producer tags and picks a forwarding source per operand */
module BypassController
    import BypassPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  PipelineCtrl      ctrl,
    input  BypassCtrlOperand intDst     [INT_ISSUE_WIDTH],
    input  BypassCtrlOperand memDst     [LOAD_ISSUE_WIDTH],
    input  OperandReq        intReq     [INT_ISSUE_WIDTH],
    input  OperandReq        memReq     [LOAD_ISSUE_WIDTH],
    output BypassOperandCtrl intCtrlOut [INT_ISSUE_WIDTH],
    output BypassOperandCtrl memCtrlOut [LOAD_ISSUE_WIDTH]
);

    // Back-end pipes
    // Int:  IS RR EX WB
    // Load: IS RR EX MT MA WB
    BypassCtrlOperand intTaps [INT_ISSUE_WIDTH][INT_TAP_DEPTH];
    BypassCtrlOperand memTaps [LOAD_ISSUE_WIDTH][MEM_TAP_DEPTH];

    BypassCtrlOperand intEx [INT_ISSUE_WIDTH];
    BypassCtrlOperand intWb [INT_ISSUE_WIDTH];
    BypassCtrlOperand memMa [LOAD_ISSUE_WIDTH];
    BypassCtrlOperand memWb [LOAD_ISSUE_WIDTH];

    BypassSelect intSelA [INT_ISSUE_WIDTH];
    BypassSelect intSelB [INT_ISSUE_WIDTH];
    BypassSelect memSelA [LOAD_ISSUE_WIDTH];
    BypassSelect memSelB [LOAD_ISSUE_WIDTH];

    // Integer producer tracking
    for (genvar i = 0; i < INT_ISSUE_WIDTH; i++) begin : gIntPipe
        DstTagPipe #(
            .DEPTH(INT_TAP_DEPTH)
        ) intPipe_inst (
            .clk  (clk),
            .rst  (rst),
            .ctrl (ctrl),
            .rrTag(intDst[i]),
            .taps (intTaps[i])
        );

        assign intEx[i] = intTaps[i][INT_TAP_EX];
        assign intWb[i] = intTaps[i][INT_TAP_WB];
    end

    // Load producer tracking, EX and MT taps are not forwarded
    for (genvar i = 0; i < LOAD_ISSUE_WIDTH; i++) begin : gMemPipe
        DstTagPipe #(
            .DEPTH(MEM_TAP_DEPTH)
        ) memPipe_inst (
            .clk  (clk),
            .rst  (rst),
            .ctrl (ctrl),
            .rrTag(memDst[i]),
            .taps (memTaps[i])
        );

        assign memMa[i] = memTaps[i][MEM_TAP_MA];
        assign memWb[i] = memTaps[i][MEM_TAP_WB];
    end

    // Operand selection for integer consumers
    for (genvar i = 0; i < INT_ISSUE_WIDTH; i++) begin : gIntSel
        BypassSelector selA_inst (
            .src  (intReq[i].srcA),
            .intEx(intEx),
            .intWb(intWb),
            .memMa(memMa),
            .memWb(memWb),
            .sel  (intSelA[i])
        );

        BypassSelector selB_inst (
            .src  (intReq[i].srcB),
            .intEx(intEx),
            .intWb(intWb),
            .memMa(memMa),
            .memWb(memWb),
            .sel  (intSelB[i])
        );

        assign intCtrlOut[i].rA = intSelA[i];
        assign intCtrlOut[i].rB = intSelB[i];
    end

    // Operand selection for load consumers
    for (genvar i = 0; i < LOAD_ISSUE_WIDTH; i++) begin : gMemSel
        BypassSelector selA_inst (
            .src  (memReq[i].srcA),
            .intEx(intEx),
            .intWb(intWb),
            .memMa(memMa),
            .memWb(memWb),
            .sel  (memSelA[i])
        );

        BypassSelector selB_inst (
            .src  (memReq[i].srcB),
            .intEx(intEx),
            .intWb(intWb),
            .memMa(memMa),
            .memWb(memWb),
            .sel  (memSelB[i])
        );

        assign memCtrlOut[i].rA = memSelA[i];
        assign memCtrlOut[i].rB = memSelB[i];
    end

endmodule : BypassController

//--- src/BypassPkg.sv
/* Bypass controller shared definitions
   Lane counts, tag widths, stage codes and the structs passed between blocks */
package BypassPkg;

    // Issue lanes per pipe group
    localparam int INT_ISSUE_WIDTH  = 2;
    localparam int LOAD_ISSUE_WIDTH = 2;

    // Width of a lane index, one bit covers two lanes
    localparam int INT_LANE_WIDTH = 1;
    localparam int MEM_LANE_WIDTH = 1;

    // Physical register file has 64 entries
    localparam int PREG_NUM_WIDTH = 6;

    // Shadow stages behind RR
    // Int: EX WB
    // Load: EX MT MA WB
    localparam int INT_TAP_DEPTH = 2;
    localparam int MEM_TAP_DEPTH = 4;

    // Tap positions that feed the forwarding match
    localparam int INT_TAP_EX = 0;
    localparam int INT_TAP_WB = 1;
    localparam int MEM_TAP_MA = 2;
    localparam int MEM_TAP_WB = 3;

    localparam int STAGE_CODE_WIDTH = 2;

    typedef logic [PREG_NUM_WIDTH-1:0] PRegNum;
    typedef logic [INT_LANE_WIDTH-1:0] IntLane;
    typedef logic [MEM_LANE_WIDTH-1:0] MemLane;

    // Forwarding source
    typedef logic [STAGE_CODE_WIDTH-1:0] BypassStage;

    localparam BypassStage STG_INT_EX = 2'd0;
    localparam BypassStage STG_INT_WB = 2'd1;
    localparam BypassStage STG_MEM_MA = 2'd2;
    localparam BypassStage STG_MEM_WB = 2'd3;

    // Producer tag carried down the shadow pipe
    typedef struct packed {
        PRegNum dstRegNum;
        logic   writeReg;
    } BypassCtrlOperand;

    // One source operand request at RR
    typedef struct packed {
        PRegNum regNum;
        logic   read;
    } SrcOperand;

    typedef struct packed {
        SrcOperand srcA;
        SrcOperand srcB;
    } OperandReq;

    // Forwarding decision for one operand
    typedef struct packed {
        logic       valid;
        BypassStage stg;
        IntLane     intLane;
        MemLane     memLane;
    } BypassSelect;

    typedef struct packed {
        BypassSelect rA;
        BypassSelect rB;
    } BypassOperandCtrl;

    // Back-end pipeline control, plain levels
    typedef struct packed {
        logic stall;
        logic clear;
    } PipelineCtrl;

endpackage : BypassPkg

//--- src/BypassSelector.sv
/* Bypass selector for one source operand
   Priority match against int EX/WB and load MA/WB producer tags */
module BypassSelector
    import BypassPkg::*;
(
    input  SrcOperand        src,
    input  BypassCtrlOperand intEx [INT_ISSUE_WIDTH],
    input  BypassCtrlOperand intWb [INT_ISSUE_WIDTH],
    input  BypassCtrlOperand memMa [LOAD_ISSUE_WIDTH],
    input  BypassCtrlOperand memWb [LOAD_ISSUE_WIDTH],
    output BypassSelect      sel
);

    logic [INT_ISSUE_WIDTH-1:0]  intExHit;
    logic [INT_ISSUE_WIDTH-1:0]  intWbHit;
    logic [LOAD_ISSUE_WIDTH-1:0] memMaHit;
    logic [LOAD_ISSUE_WIDTH-1:0] memWbHit;

    logic       intFound;
    logic       memFound;
    BypassStage intStg;
    BypassStage memStg;
    IntLane     intLane;
    MemLane     memLane;

    function automatic logic TagHit(BypassCtrlOperand tag, PRegNum regNum);
        return tag.writeReg && (tag.dstRegNum == regNum);
    endfunction

    // Raw tag matches, gated by the read request
    always_comb begin
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            intExHit[i] = src.read && TagHit(intEx[i], src.regNum);
            intWbHit[i] = src.read && TagHit(intWb[i], src.regNum);
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            memMaHit[i] = src.read && TagHit(memMa[i], src.regNum);
            memWbHit[i] = src.read && TagHit(memWb[i], src.regNum);
        end
    end

    // Integer side, lowest lane first and EX ahead of WB
    always_comb begin
        intFound = 1'b0;
        intStg   = STG_INT_EX;
        intLane  = '0;
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            if (!intFound) begin
                if (intExHit[i]) begin
                    intFound = 1'b1;
                    intStg   = STG_INT_EX;
                    intLane  = IntLane'(i);
                end else if (intWbHit[i]) begin
                    intFound = 1'b1;
                    intStg   = STG_INT_WB;
                    intLane  = IntLane'(i);
                end
            end
        end
    end

    // Load side, same order with MA ahead of WB
    always_comb begin
        memFound = 1'b0;
        memStg   = STG_MEM_MA;
        memLane  = '0;
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            if (!memFound) begin
                if (memMaHit[i]) begin
                    memFound = 1'b1;
                    memStg   = STG_MEM_MA;
                    memLane  = MemLane'(i);
                end else if (memWbHit[i]) begin
                    memFound = 1'b1;
                    memStg   = STG_MEM_WB;
                    memLane  = MemLane'(i);
                end
            end
        end
    end

    // A load hit takes the stage but the recorded int lane stays
    always_comb begin
        sel.valid   = intFound || memFound;
        sel.intLane = intLane;
        sel.memLane = memLane;
        if (memFound) begin
            sel.stg = memStg;
        end else if (intFound) begin
            sel.stg = intStg;
        end else begin
            sel.stg = STG_INT_EX;
        end
    end

endmodule : BypassSelector

//--- src/DstTagPipe.sv
/* Destination tag shadow pipe
   Carries one lane's producer tag through DEPTH stages and exposes every stage */
module DstTagPipe
    import BypassPkg::*;
#(
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  PipelineCtrl      ctrl,
    input  BypassCtrlOperand rrTag,
    output BypassCtrlOperand taps [DEPTH]
);

    BypassCtrlOperand stage [DEPTH];
    logic             flush;
    logic             advance;

    // Clear wins over stall
    assign flush   = rst || ctrl.clear;
    assign advance = !ctrl.stall;

    // First stage takes the RR tag
    always_ff @(posedge clk) begin
        if (flush) begin
            stage[0] <= '0;
        end else if (advance) begin
            stage[0] <= rrTag;
        end
    end

    // Remaining stages shift behind it
    for (genvar s = 1; s < DEPTH; s++) begin : gStage
        always_ff @(posedge clk) begin
            if (flush) begin
                stage[s] <= '0;
            end else if (advance) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    // Every stage is a tap for the consumers
    always_comb begin
        for (int s = 0; s < DEPTH; s++) begin
            taps[s] = stage[s];
        end
    end

endmodule : DstTagPipe

//--- test/BypassControllerTb.sv
/* Testbench for the bypass controller
   Directed and random producer traffic checked against a reference model every cycle */
module BypassControllerTb
    import BypassPkg::*;
();

    logic             clk;
    logic             rst;
    PipelineCtrl      ctrl;
    BypassCtrlOperand intDst     [INT_ISSUE_WIDTH];
    BypassCtrlOperand memDst     [LOAD_ISSUE_WIDTH];
    OperandReq        intReq     [INT_ISSUE_WIDTH];
    OperandReq        memReq     [LOAD_ISSUE_WIDTH];
    BypassOperandCtrl intCtrlOut [INT_ISSUE_WIDTH];
    BypassOperandCtrl memCtrlOut [LOAD_ISSUE_WIDTH];

    // Reference tag histories with index 0 right after RR
    BypassCtrlOperand refInt [INT_ISSUE_WIDTH][INT_TAP_DEPTH];
    BypassCtrlOperand refMem [LOAD_ISSUE_WIDTH][MEM_TAP_DEPTH];

    int errors;
    int checks;
    int testsRun;

    BypassController BypassController_inst (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .intDst    (intDst),
        .memDst    (memDst),
        .intReq    (intReq),
        .memReq    (memReq),
        .intCtrlOut(intCtrlOut),
        .memCtrlOut(memCtrlOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        #10000;
        $display("Simulation did not finish in time, stopping");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Flush beats stall in the reference history
    always @(posedge clk) begin
        if (rst || ctrl.clear) begin
            for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                for (int s = 0; s < INT_TAP_DEPTH; s++) begin
                    refInt[i][s] = '0;
                end
            end
            for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
                for (int s = 0; s < MEM_TAP_DEPTH; s++) begin
                    refMem[i][s] = '0;
                end
            end
        end else if (!ctrl.stall) begin
            for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                for (int s = INT_TAP_DEPTH - 1; s > 0; s--) begin
                    refInt[i][s] = refInt[i][s-1];
                end
                refInt[i][0] = intDst[i];
            end
            for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
                for (int s = MEM_TAP_DEPTH - 1; s > 0; s--) begin
                    refMem[i][s] = refMem[i][s-1];
                end
                refMem[i][0] = memDst[i];
            end
        end
    end

    function automatic logic tagMatches(BypassCtrlOperand tag, PRegNum regNum);
        return tag.writeReg && (tag.dstRegNum == regNum);
    endfunction

    // Int lanes scanned before load lanes
    // A load hit replaces the stage but keeps intLane
    function automatic BypassSelect expectSelect(SrcOperand src);
        BypassSelect res;
        logic        intFound;
        logic        memFound;
        res      = '0;
        intFound = 1'b0;
        memFound = 1'b0;
        if (src.read) begin
            for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                if (!intFound && tagMatches(refInt[i][INT_TAP_EX], src.regNum)) begin
                    intFound    = 1'b1;
                    res.stg     = STG_INT_EX;
                    res.intLane = IntLane'(i);
                end else if (!intFound && tagMatches(refInt[i][INT_TAP_WB], src.regNum)) begin
                    intFound    = 1'b1;
                    res.stg     = STG_INT_WB;
                    res.intLane = IntLane'(i);
                end
            end
            for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
                if (!memFound && tagMatches(refMem[i][MEM_TAP_MA], src.regNum)) begin
                    memFound    = 1'b1;
                    res.stg     = STG_MEM_MA;
                    res.memLane = MemLane'(i);
                end else if (!memFound && tagMatches(refMem[i][MEM_TAP_WB], src.regNum)) begin
                    memFound    = 1'b1;
                    res.stg     = STG_MEM_WB;
                    res.memLane = MemLane'(i);
                end
            end
        end
        res.valid = intFound || memFound;
        return res;
    endfunction

    task automatic checkOperand(string group, int lane, string opName, SrcOperand src,
                                BypassSelect got);
        BypassSelect exp;
        exp = expectSelect(src);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s lane %0d operand %s: got %b expected %b",
                     $time, group, lane, opName, got, exp);
        end
    endtask

    // Outputs are settled one time unit before the next edge
    initial begin : compareOutputs
        forever begin
            @(posedge clk);
            #3;
            if (!rst) begin
                for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                    checkOperand("int", i, "A", intReq[i].srcA, intCtrlOut[i].rA);
                    checkOperand("int", i, "B", intReq[i].srcB, intCtrlOut[i].rB);
                end
                for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
                    checkOperand("load", i, "A", memReq[i].srcA, memCtrlOut[i].rA);
                    checkOperand("load", i, "B", memReq[i].srcB, memCtrlOut[i].rB);
                end
            end
        end
    end

    function automatic BypassCtrlOperand producerTag(PRegNum regNum);
        return '{dstRegNum: regNum, writeReg: 1'b1};
    endfunction

    function automatic SrcOperand readReq(PRegNum regNum);
        return '{regNum: regNum, read: 1'b1};
    endfunction

    function automatic BypassSelect makeSelect(BypassStage stg, int intLane, int memLane);
        return '{valid: 1'b1, stg: stg, intLane: IntLane'(intLane), memLane: MemLane'(memLane)};
    endfunction

    function automatic SrcOperand randomSrc();
        return '{regNum: PRegNum'($urandom_range(7)), read: ($urandom_range(1) == 1)};
    endfunction

    task automatic idleProducers();
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            intDst[i] = '0;
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            memDst[i] = '0;
        end
    endtask

    task automatic idleInputs();
        ctrl = '0;
        idleProducers();
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            intReq[i] = '0;
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            memReq[i] = '0;
        end
    endtask

    // Drive point sits one unit after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expectSel(string what, BypassSelect got, BypassSelect exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Producer only lives in the cycle it was driven
    task automatic waitForForward(input int maxCycles, output int cycles);
        logic found;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < maxCycles) begin
            nextCycle();
            idleProducers();
            cycles++;
            #1;
            found = intCtrlOut[0].rA.valid;
        end
        assert (found) else begin
            errors++;
            $display("No forward on int lane 0 operand A within %0d cycles", maxCycles);
        end
    endtask

    task automatic finishTest(string name, int errorsBefore);
        testsRun++;
        if (errors == errorsBefore) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    initial begin : mainSequence
        int cycles;
        int errorsBefore;
        void'($urandom(32'h21cfd934));
        errors   = 0;
        checks   = 0;
        testsRun = 0;
        rst      = 1'b1;
        idleInputs();

        errorsBefore = errors;
        for (int c = 0; c < 2; c++) begin
            nextCycle();
        end
        rst = 1'b0;
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            intReq[i] = '{srcA: readReq(PRegNum'(i)), srcB: readReq(PRegNum'(i + 4))};
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            memReq[i] = '{srcA: readReq(PRegNum'(i + 2)), srcB: readReq(PRegNum'(i + 6))};
        end
        nextCycle();
        #1;
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            expectSel("int rA after reset", intCtrlOut[i].rA, '0);
            expectSel("int rB after reset", intCtrlOut[i].rB, '0);
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            expectSel("load rA after reset", memCtrlOut[i].rA, '0);
            expectSel("load rB after reset", memCtrlOut[i].rB, '0);
        end
        finishTest("reset", errorsBefore);

        errorsBefore = errors;
        nextCycle();
        idleInputs();
        intDst[1]      = producerTag(6'd5);
        intReq[0].srcA = readReq(6'd5);
        waitForForward(8, cycles);
        expectSel("int EX latency", (cycles == 1) ? 5'b1 : 5'b0, 5'b1);
        expectSel("int forward at EX", intCtrlOut[0].rA, makeSelect(STG_INT_EX, 1, 0));
        nextCycle();
        #1;
        expectSel("int forward at WB", intCtrlOut[0].rA, makeSelect(STG_INT_WB, 1, 0));
        nextCycle();
        #1;
        expectSel("int forward after WB", intCtrlOut[0].rA, '0);
        finishTest("int forward", errorsBefore);

        errorsBefore = errors;
        nextCycle();
        idleInputs();
        memDst[0]      = producerTag(6'd9);
        intReq[0].srcA = readReq(6'd9);
        waitForForward(8, cycles);
        expectSel("load MA latency", (cycles == 3) ? 5'b1 : 5'b0, 5'b1);
        expectSel("load forward at MA", intCtrlOut[0].rA, makeSelect(STG_MEM_MA, 0, 0));
        nextCycle();
        #1;
        expectSel("load forward at WB", intCtrlOut[0].rA, makeSelect(STG_MEM_WB, 0, 0));
        nextCycle();
        #1;
        expectSel("load forward after WB", intCtrlOut[0].rA, '0);
        finishTest("load forward", errorsBefore);

        // Overlapping producers of r7 and r3 to exercise every priority rule
        errorsBefore = errors;
        nextCycle();
        idleInputs();
        intReq[0].srcA = readReq(6'd7);
        intReq[0].srcB = readReq(6'd3);
        memDst[1]      = producerTag(6'd7);
        nextCycle();
        idleProducers();
        memDst[0] = producerTag(6'd7);
        intDst[1] = producerTag(6'd3);
        nextCycle();
        intDst[0] = producerTag(6'd7);
        nextCycle();
        idleProducers();
        intDst[0] = producerTag(6'd7);
        intDst[1] = producerTag(6'd7);
        #1;
        expectSel("load over int", intCtrlOut[0].rA, makeSelect(STG_MEM_MA, 0, 1));
        expectSel("int EX over WB", intCtrlOut[0].rB, makeSelect(STG_INT_EX, 1, 0));
        nextCycle();
        idleProducers();
        #1;
        expectSel("lower lane wins", intCtrlOut[0].rA, makeSelect(STG_MEM_MA, 0, 0));
        expectSel("int WB only", intCtrlOut[0].rB, makeSelect(STG_INT_WB, 1, 0));
        nextCycle();
        #1;
        expectSel("load MA over WB", intCtrlOut[0].rA, makeSelect(STG_MEM_MA, 0, 0));
        expectSel("no r3 producer", intCtrlOut[0].rB, '0);
        nextCycle();
        #1;
        expectSel("load WB last", intCtrlOut[0].rA, makeSelect(STG_MEM_WB, 0, 0));
        finishTest("priority", errorsBefore);

        errorsBefore = errors;
        nextCycle();
        idleInputs();
        intReq[0].srcA = readReq(6'd4);
        intDst[0]      = producerTag(6'd4);
        nextCycle();
        idleProducers();
        ctrl.stall = 1'b1;
        for (int c = 0; c < 3; c++) begin
            #1;
            expectSel("stalled at EX", intCtrlOut[0].rA, makeSelect(STG_INT_EX, 0, 0));
            nextCycle();
        end
        ctrl.stall = 1'b0;
        #1;
        expectSel("stalled at EX", intCtrlOut[0].rA, makeSelect(STG_INT_EX, 0, 0));
        nextCycle();
        intDst[1] = producerTag(6'd4);
        #1;
        expectSel("WB after stall", intCtrlOut[0].rA, makeSelect(STG_INT_WB, 0, 0));
        nextCycle();
        idleProducers();
        ctrl = '{stall: 1'b1, clear: 1'b1};
        nextCycle();
        ctrl = '0;
        #1;
        expectSel("cleared", intCtrlOut[0].rA, '0);
        finishTest("stall and clear", errorsBefore);

        errorsBefore = errors;
        nextCycle();
        for (int c = 0; c < 500; c++) begin
            for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                intDst[i] = '{dstRegNum: PRegNum'($urandom_range(7)),
                              writeReg: ($urandom_range(1) == 1)};
                intReq[i] = '{srcA: randomSrc(), srcB: randomSrc()};
            end
            for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
                memDst[i] = '{dstRegNum: PRegNum'($urandom_range(7)),
                              writeReg: ($urandom_range(1) == 1)};
                memReq[i] = '{srcA: randomSrc(), srcB: randomSrc()};
            end
            ctrl.stall = ($urandom_range(7) == 0);
            ctrl.clear = ($urandom_range(15) == 0);
            nextCycle();
        end
        idleInputs();
        nextCycle();
        finishTest("random traffic", errorsBefore);

        // Bound property failures count as errors too
        errors += BypassController_inst.asserts_inst.failures;

        $display("Tests: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : BypassControllerTb

//--- test/BypassController_asserts.sv
/* Bound checks on the bypass controller outputs
   Flushed pipes forward nothing, and a forward needs a read request */
module BypassController_asserts
    import BypassPkg::*;
(
    input logic             clk,
    input logic             rst,
    input PipelineCtrl      ctrl,
    input OperandReq        intReq     [INT_ISSUE_WIDTH],
    input OperandReq        memReq     [LOAD_ISSUE_WIDTH],
    input BypassOperandCtrl intCtrlOut [INT_ISSUE_WIDTH],
    input BypassOperandCtrl memCtrlOut [LOAD_ISSUE_WIDTH]
);

    logic anyValid;
    logic validWithoutRead;
    int   failures = 0;

    always_comb begin
        anyValid         = 1'b0;
        validWithoutRead = 1'b0;
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            anyValid = anyValid || intCtrlOut[i].rA.valid || intCtrlOut[i].rB.valid;
            validWithoutRead = validWithoutRead
                || (intCtrlOut[i].rA.valid && !intReq[i].srcA.read)
                || (intCtrlOut[i].rB.valid && !intReq[i].srcB.read);
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            anyValid = anyValid || memCtrlOut[i].rA.valid || memCtrlOut[i].rB.valid;
            validWithoutRead = validWithoutRead
                || (memCtrlOut[i].rA.valid && !memReq[i].srcA.read)
                || (memCtrlOut[i].rB.valid && !memReq[i].srcB.read);
        end
    end

    // Every tag is dropped on the flush edge
    flushDropsForwards: assert property (@(posedge clk) (rst || ctrl.clear) |=> !anyValid)
        else begin
            failures++;
            $error("Forward reported in the cycle after reset or clear");
        end

    validNeedsRead: assert property (@(posedge clk) disable iff (rst) !validWithoutRead)
        else begin
            failures++;
            $error("Forward reported for an operand that is not read");
        end

endmodule : BypassController_asserts

bind BypassController BypassController_asserts asserts_inst (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .intReq    (intReq),
    .memReq    (memReq),
    .intCtrlOut(intCtrlOut),
    .memCtrlOut(memCtrlOut)
);
